// File: logic/wand_pkg.sv
/* Sizes, frame and phase encodings, and the colour and position sine tables
   shared by the wand frame generator and its testbench */
package wand_pkg;

  // Last position in a string: start frame at 0, pixels 1 to 46, end frame at 47
  localparam logic [7:0] string_size = 8'd47;

  // The colour table covers one full sine period
  localparam int total_cycle_size = 60;

  // Number of strings a channel spends in one phase
  localparam int color_state_size = 30;

  // Offsets into the colour table for rising and falling channels
  localparam int sine_ascend_start = 30;
  localparam int sine_descend_start = 0;

  // Position table length and the gap between the handle and the lowest line point
  localparam int wand_sine_size = 40;
  localparam logic [7:0] wand_sine_base = 8'd3;

  // Channel level of the white line
  localparam logic [7:0] white_level = 8'd150;

  // Global brightness field of a pixel frame, always full scale here
  localparam logic [4:0] full_brightness = 5'd31;

  // Serial frame length and sck half-period in clocks
  localparam int frame_bits = 32;
  localparam int sck_half = 1;

  typedef enum logic [1:0] {frame_start, frame_pixel, frame_end} frame_kind_e;

  typedef enum logic [1:0] {phase_zero, phase_ascend, phase_descend} channel_phase_e;

  typedef enum logic [1:0] {st_wait, st_load, st_send, st_advance} seq_state_e;

  // One phase per primary colour, packed blue first
  typedef struct packed {
    channel_phase_e blue;
    channel_phase_e green;
    channel_phase_e red;
  } rgb_phase_t;

  // Colour sine, falling half from index 0 and rising half from index 30
  localparam logic [7:0] color_sin [total_cycle_size] = '{
    200, 199, 197, 195, 191, 186, 180, 174, 166, 158,
    150, 140, 130, 120, 110, 100,  89,  79,  69,  59,
     49,  41,  33,  25,  19,  13,   8,   4,   2,   0,
      0,   0,   2,   4,   8,  13,  19,  25,  33,  41,
     49,  59,  69,  79,  89, 100, 110, 120, 130, 140,
    150, 158, 166, 174, 180, 186, 191, 195, 197, 199
  };

  // Height of the white line above its base, one entry per string
  localparam logic [7:0] wand_position_sin [wand_sine_size] = '{
    20, 23, 26, 29, 31, 34, 36, 37, 39, 39,
    40, 39, 39, 37, 36, 34, 31, 29, 26, 23,
    20, 16, 13, 10,  8,  5,  3,  2,  0,  0,
     0,  0,  0,  2,  3,  5,  8, 10, 13, 16
  };

endpackage

// File: logic/led_frame_if.sv
/* Frame request channel from the pixel sequencer to the serial shifter */
interface led_frame_if import wand_pkg::*; ();

  // Frame kind and colour bytes, held steady by the source while busy is high
  frame_kind_e kind;
  logic [7:0] blue;
  logic [7:0] green;
  logic [7:0] red;

  // One-cycle request, only issued while busy is low
  logic start;

  // High from the edge that takes start until the last bit has gone out
  logic busy;

  modport source (
    output kind, blue, green, red, start,
    input busy
  );

  modport sink (
    input kind, blue, green, red, start,
    output busy
  );

endinterface

// File: logic/color_phase.sv
/* Per-string colour state: stage counter, top and bottom channel phases
   and the white-line position taken from the position table */
module color_phase import wand_pkg::*; (
  input logic dostring_clk,
  input logic dostring_reset,
  input logic string_done,
  output logic [4:0] stage,
  output rgb_phase_t top,
  output rgb_phase_t bottom,
  output logic [7:0] middle_point
);

  // Index into the position table, one step per finished string
  logic [5:0] position_index;
  logic [5:0] next_index;
  logic stage_wrap;

  // Each channel walks flat, then up, then down, and back to flat
  function automatic channel_phase_e step_phase(channel_phase_e phase);
    channel_phase_e next_phase;
    case (phase)
      phase_zero:
      begin
        next_phase = phase_ascend;
      end
      phase_ascend:
      begin
        next_phase = phase_descend;
      end
      default:
      begin
        next_phase = phase_zero;
      end
    endcase
    return next_phase;
  endfunction

  // All three channels of a region rotate together
  function automatic rgb_phase_t step_rgb(rgb_phase_t phase);
    rgb_phase_t next_rgb;
    next_rgb.blue = step_phase(phase.blue);
    next_rgb.green = step_phase(phase.green);
    next_rgb.red = step_phase(phase.red);
    return next_rgb;
  endfunction

  // The position table wraps after its last entry
  assign next_index = (position_index == 6'(wand_sine_size - 1)) ? 6'd0 : position_index + 6'd1;

  // A phase lasts color_state_size strings
  assign stage_wrap = (stage == 5'(color_state_size - 1));

  always_ff @(posedge dostring_clk or posedge dostring_reset)
  begin
    if (dostring_reset)
    begin
      stage <= 5'd0;
      position_index <= 6'd0;
      middle_point <= wand_position_sin[0];
      // Top starts with blue falling into green rising
      top <= '{blue: phase_descend, green: phase_ascend, red: phase_zero};
      // Bottom is offset by one phase so the two regions differ
      bottom <= '{blue: phase_zero, green: phase_descend, red: phase_ascend};
    end
    else if (string_done)
    begin
      position_index <= next_index;
      middle_point <= wand_position_sin[next_index];
      if (stage_wrap)
      begin
        stage <= 5'd0;
        top <= step_rgb(top);
        bottom <= step_rgb(bottom);
      end
      else
      begin
        stage <= stage + 5'd1;
      end
    end
  end

endmodule

// File: logic/pixel_sequencer.sv
/* Frame sequencer: walks the 48 positions of a string, picks the frame kind
   and computes each pixel's colour from the region and the channel phases */
module pixel_sequencer import wand_pkg::*; (
  input logic dostring_clk,
  input logic dostring_reset,
  led_frame_if.source frame,
  input logic [4:0] stage,
  input rgb_phase_t top,
  input rgb_phase_t bottom,
  input logic [7:0] middle_point,
  output logic string_done
);

  seq_state_e state;

  // Position in the string, 0 is the start frame next to the handle
  logic [7:0] position;

  // Position of the white line on the wand for this string
  logic [7:0] line_position;
  logic on_line;
  rgb_phase_t region_phase;

  frame_kind_e next_kind;
  logic [7:0] next_blue;
  logic [7:0] next_green;
  logic [7:0] next_red;

  // Channel level for a phase at the current stage of the colour cycle
  function automatic logic [7:0] channel_value(channel_phase_e phase, logic [4:0] step);
    logic [7:0] value;
    case (phase)
      phase_ascend:
      begin
        value = color_sin[sine_ascend_start + int'(step)];
      end
      phase_descend:
      begin
        value = color_sin[sine_descend_start + int'(step)];
      end
      default:
      begin
        value = 8'd0;
      end
    endcase
    return value;
  endfunction

  assign line_position = wand_sine_base + middle_point;
  assign on_line = (position == line_position);

  // Pixels between the handle and the line take the top phases
  assign region_phase = (position < line_position) ? top : bottom;

  always_comb
  begin
    if (position == 8'd0)
    begin
      next_kind = frame_start;
    end
    else if (position == string_size)
    begin
      next_kind = frame_end;
    end
    else
    begin
      next_kind = frame_pixel;
    end
  end

  always_comb
  begin
    if (next_kind != frame_pixel)
    begin
      // Start and end frames carry no colour
      next_blue = 8'd0;
      next_green = 8'd0;
      next_red = 8'd0;
    end
    else if (on_line)
    begin
      next_blue = white_level;
      next_green = white_level;
      next_red = white_level;
    end
    else
    begin
      next_blue = channel_value(region_phase.blue, stage);
      next_green = channel_value(region_phase.green, stage);
      next_red = channel_value(region_phase.red, stage);
    end
  end

  // Frame contents are captured in st_load and stay put while the shifter is busy
  always_ff @(posedge dostring_clk)
  begin
    if (state == st_load)
    begin
      frame.kind <= next_kind;
      frame.blue <= next_blue;
      frame.green <= next_green;
      frame.red <= next_red;
    end
  end

  always_ff @(posedge dostring_clk or posedge dostring_reset)
  begin
    if (dostring_reset)
    begin
      state <= st_wait;
      position <= 8'd0;
      frame.start <= 1'b0;
      string_done <= 1'b0;
    end
    else
    begin
      string_done <= 1'b0;
      case (state)
        st_wait:
        begin
          // Nothing moves until the shifter has let go of the last frame
          if (!frame.busy)
          begin
            state <= st_load;
          end
        end
        st_load:
        begin
          // Start goes high together with the freshly loaded frame
          frame.start <= 1'b1;
          state <= st_send;
        end
        st_send:
        begin
          frame.start <= 1'b0;
          state <= st_advance;
        end
        default:
        begin
          // The end frame has been handed off, so the string is complete
          if (position == string_size)
          begin
            position <= 8'd0;
            string_done <= 1'b1;
          end
          else
          begin
            position <= position + 8'd1;
          end
          state <= st_wait;
        end
      endcase
    end
  end

endmodule

// File: logic/led_spi_shifter.sv
/* Serial LED driver: builds a 32-bit frame word and shifts it out MSB first,
   mosi changing with sck low and sck high in the second half of each bit */
module led_spi_shifter import wand_pkg::*; (
  input logic dostring_clk,
  input logic dostring_reset,
  led_frame_if.sink frame,
  output logic mosi,
  output logic sck
);

  logic [frame_bits-1:0] load_word;
  logic [frame_bits-1:0] shift_word;

  // Bit index within the frame
  logic [4:0] bit_count;
  logic last_bit;

  always_comb
  begin
    case (frame.kind)
      frame_start:
      begin
        load_word = '0;
      end
      frame_pixel:
      begin
        // Three marker ones, brightness, then blue, green, red
        load_word = {3'b111, full_brightness, frame.blue, frame.green, frame.red};
      end
      default:
      begin
        load_word = '1;
      end
    endcase
  end

  assign last_bit = (bit_count == 5'(frame_bits - 1));

  // The top bit of the shift register is the line
  assign mosi = shift_word[frame_bits-1];

  always_ff @(posedge dostring_clk or posedge dostring_reset)
  begin
    if (dostring_reset)
    begin
      shift_word <= '0;
      bit_count <= 5'd0;
      sck <= 1'b0;
      frame.busy <= 1'b0;
    end
    else if (!frame.busy)
    begin
      // The first bit is on mosi from the edge that takes the request
      if (frame.start)
      begin
        shift_word <= load_word;
        bit_count <= 5'd0;
        sck <= 1'b0;
        frame.busy <= 1'b1;
      end
    end
    else if (!sck)
    begin
      // Data has been stable for a half-period, so the LED can sample it
      sck <= 1'b1;
    end
    else
    begin
      sck <= 1'b0;
      if (last_bit)
      begin
        // mosi keeps the last bit until the next frame
        frame.busy <= 1'b0;
      end
      else
      begin
        bit_count <= bit_count + 5'd1;
        shift_word <= shift_word << 1;
      end
    end
  end

endmodule

// File: logic/dostring_wave.sv
/* Top level of the wand frame generator: colour state, sequencer and shifter */
module dostring_wave import wand_pkg::*; (
  input logic dostring_clk,
  input logic dostring_reset,
  output logic mosi,
  output logic sck
);

  // Frame request channel between sequencer and shifter
  led_frame_if frame_bus ();

  // Colour state for the string that is currently going out
  logic [4:0] stage;
  rgb_phase_t top_phase;
  rgb_phase_t bottom_phase;
  logic [7:0] middle_point;

  // Pulses once per string after the end frame is handed off
  logic string_done;

  color_phase u_phase (
    .dostring_clk(dostring_clk),
    .dostring_reset(dostring_reset),
    .string_done(string_done),
    .stage(stage),
    .top(top_phase),
    .bottom(bottom_phase),
    .middle_point(middle_point)
  );

  pixel_sequencer u_sequencer (
    .dostring_clk(dostring_clk),
    .dostring_reset(dostring_reset),
    .frame(frame_bus.source),
    .stage(stage),
    .top(top_phase),
    .bottom(bottom_phase),
    .middle_point(middle_point),
    .string_done(string_done)
  );

  led_spi_shifter u_shifter (
    .dostring_clk(dostring_clk),
    .dostring_reset(dostring_reset),
    .frame(frame_bus.sink),
    .mosi(mosi),
    .sck(sck)
  );

endmodule

// File: bench/wave_asserts.sv
/* Concurrent protocol checks on the serial LED lines, bound to the top level */
module wave_asserts (
  input logic dostring_clk,
  input logic dostring_reset,
  input logic mosi,
  input logic sck
);

  // Failures seen so far, read by the testbench for its closing report
  int fail_count = 0;

  // Both lines sit low while reset is held and on the first edge after it
  reset_quiet: assert property (
    @(posedge dostring_clk)
    (dostring_reset || $past(dostring_reset)) |-> (!sck && !mosi)
  )
  else
  begin
    fail_count = fail_count + 1;
    $error("sck or mosi not low during or right after reset");
  end

  // The LED samples on the rising sck edge, so data may only move with sck low
  mosi_setup: assert property (
    @(posedge dostring_clk) disable iff (dostring_reset)
    $changed(mosi) |-> !sck
  )
  else
  begin
    fail_count = fail_count + 1;
    $error("mosi changed while sck was high");
  end

  // With a one-clock half-period sck is never high for two cycles in a row
  sck_pulse: assert property (
    @(posedge dostring_clk) disable iff (dostring_reset)
    sck |=> !sck
  )
  else
  begin
    fail_count = fail_count + 1;
    $error("sck stayed high for more than one cycle");
  end

endmodule

bind dostring_wave wave_asserts u_asserts (
  .dostring_clk(dostring_clk),
  .dostring_reset(dostring_reset),
  .mosi(mosi),
  .sck(sck)
);

// File: bench/wave_tb.sv
/* Testbench for the wand frame generator: clock, reset, serial frame decoder,
   string reference model, frame checks and the closing report */
module wave_tb import wand_pkg::*; ();

  // Strings to decode and the cycle limit, 32 x 48 x 67 plus a margin
  localparam int run_strings = 32;
  localparam int timeout_cycles = 115000;

  logic dostring_clk;
  logic dostring_reset;
  logic mosi;
  logic sck;

  // Decoder state, sampled on the falling clock edge where all outputs are settled
  logic prev_sck = 1'b0;
  logic [31:0] shift_in = '0;
  int bit_num = 0;

  // Reference model of the string position and the colour state
  int model_pos = 0;
  int model_stage = 0;
  int model_index = 0;
  logic [7:0] model_middle = wand_position_sin[0];
  rgb_phase_t model_top = '{blue: phase_descend, green: phase_ascend, red: phase_zero};
  rgb_phase_t model_bottom = '{blue: phase_zero, green: phase_descend, red: phase_ascend};

  int strings_done = 0;
  int value_errors = 0;
  int cycle_count = 0;

  dostring_wave UUT (
    .dostring_clk(dostring_clk),
    .dostring_reset(dostring_reset),
    .mosi(mosi),
    .sck(sck)
  );

  initial
  begin
    dostring_clk = 1'b0;
    forever #5 dostring_clk = ~dostring_clk;
  end

  // Flat channels are dark, rising and falling ones read the sine from their own offset
  function automatic logic [7:0] expected_level(channel_phase_e phase, int step);
    if (phase == phase_ascend)
      return color_sin[sine_ascend_start + step];
    if (phase == phase_descend)
      return color_sin[sine_descend_start + step];
    return 8'd0;
  endfunction

  // Phases cycle zero, ascend, descend in enum order
  function automatic channel_phase_e next_phase(channel_phase_e phase);
    return channel_phase_e'((int'(phase) + 1) % 3);
  endfunction

  task automatic report_value(input string what, input logic [31:0] got,
                              input logic [31:0] want);
    value_errors = value_errors + 1;
    $display("ERR %0t: %s at position %0d of string %0d, got %h expected %h",
             $time, what, model_pos, strings_done, got, want);
  endtask

  // Move the model to the next string once its end frame has been seen
  task automatic finish_string();
    strings_done = strings_done + 1;
    model_stage = model_stage + 1;
    if (model_stage == color_state_size)
    begin
      model_stage = 0;
      model_top = '{next_phase(model_top.blue), next_phase(model_top.green),
                    next_phase(model_top.red)};
      model_bottom = '{next_phase(model_bottom.blue), next_phase(model_bottom.green),
                       next_phase(model_bottom.red)};
    end
    model_index = (model_index + 1) % wand_sine_size;
    model_middle = wand_position_sin[model_index];
  endtask

  task automatic check_word(input logic [31:0] word);
    logic [31:0] expected;
    int line;
    rgb_phase_t region;
    line = int'(wand_sine_base) + int'(model_middle);
    region = (model_pos < line) ? model_top : model_bottom;
    if (model_pos == 0)
    begin
      assert (word == 32'h0000_0000) else report_value("start frame not zero", word, '0);
    end
    else if (model_pos == int'(string_size))
    begin
      assert (word == 32'hffff_ffff) else report_value("end frame not ones", word, '1);
    end
    else
    begin
      if (model_pos == line)
        expected = {3'b111, full_brightness, white_level, white_level, white_level};
      else
        expected = {3'b111, full_brightness, expected_level(region.blue, model_stage),
                    expected_level(region.green, model_stage),
                    expected_level(region.red, model_stage)};
      assert (word[31:24] == expected[31:24])
      else report_value("pixel header wrong", word, expected);
      assert (word[23:0] == expected[23:0])
      else report_value("pixel colour wrong", word, expected);
    end
    if (model_pos == int'(string_size))
    begin
      model_pos = 0;
      finish_string();
    end
    else
    begin
      model_pos = model_pos + 1;
    end
  endtask

  // A bit is taken when sck has just gone high, a word closes every 32 bits
  always @(negedge dostring_clk)
  begin
    if (sck && !prev_sck)
    begin
      shift_in = {shift_in[30:0], mosi};
      bit_num = bit_num + 1;
      if (bit_num == frame_bits)
      begin
        check_word(shift_in);
        bit_num = 0;
      end
    end
    prev_sck = sck;
  end

  always @(posedge dostring_clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_cycles)
    begin
      $display("Timeout after %0d cycles with only %0d strings decoded",
               cycle_count, strings_done);
      $display("tests failed");
      $finish;
    end
  end

  initial
  begin
    dostring_reset = 1'b1;
    repeat (2) @(negedge dostring_clk);
    dostring_reset = 1'b0;
    wait (strings_done == run_strings);
    @(negedge dostring_clk);
    $display("Value errors %0d, protocol errors %0d", value_errors, UUT.u_asserts.fail_count);
    if (value_errors == 0 && UUT.u_asserts.fail_count == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

// File: build.f
logic/wand_pkg.sv
logic/led_frame_if.sv
logic/color_phase.sv
logic/pixel_sequencer.sv
logic/led_spi_shifter.sv
logic/dostring_wave.sv
bench/wave_asserts.sv
bench/wave_tb.sv

// File: run.sh
#!/bin/sh
# Build the wand testbench with Verilator, run it into a log and look for the pass line
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module wave_tb -o wave_sim \
  && ./obj_dir/wave_sim > sim.log 2>&1 \
  || { echo "FAIL: build or simulation error, see sim.log"; exit 1; }
grep -q "all tests passed" sim.log \
  && echo "PASS" \
  || { echo "FAIL: see sim.log"; exit 1; }
